//--- include/loader_cfg.svh
`ifndef LOADER_CFG_SVH
`define LOADER_CFG_SVH

// Bytes in one SD sector
`define SECTOR_BYTES 512

// Sectors fetched per group, kept small for simulation
`define SECTORS_PER_GROUP 4

// Sector distance between consecutive group bases
`define GROUP_STRIDE 100

// Groups visited before the base wraps back to 0
`define GROUP_COUNT 5

// Largest prime below 2**16
`define CHECKSUM_MOD 65521

// Stable cycles the button needs, 10 ms at 25 MHz
`define DEBOUNCE_CYCLES 250000

`endif

//--- hw/loader_pkg.sv
package loader_pkg;

    // Load controller states
    typedef enum logic [2:0] {
        INIT,        // Latch sector number
        WAIT_READY,  // Wait for SD controller idle
        READ,        // Request issued, bytes streaming
        WAIT_SECTOR, // Sector done, wait for controller
        SUM,         // Checksum pass over the buffer
        DONE         // Result shown, wait for press
    } load_state_t;

    typedef logic [7:0]  byte_t;   // SD data byte
    typedef logic [15:0] word_t;   // Buffer word, also checksum width
    typedef logic [31:0] sector_t; // SD sector address

endpackage

//--- hw/buf_if.sv
`timescale 1ns/10ps
`include "loader_cfg.svh"

// Byte path into the sector buffer plus the checksum read port
interface buf_if #(
    parameter int AW = $clog2(`SECTORS_PER_GROUP * `SECTOR_BYTES / 2)
);
    import loader_pkg::*;

    logic          byte_valid; // One-cycle strobe per accepted byte
    byte_t         byte_data;
    logic          clear;      // Group restart
    logic [AW-1:0] rd_addr;
    word_t         rd_data;    // Registered, one cycle after rd_addr
    logic [AW:0]   word_count; // Words written since clear

    modport writer (output byte_valid, byte_data, clear);
    modport store  (input byte_valid, byte_data, clear, rd_addr, output rd_data, word_count);
    modport reader (output rd_addr, input rd_data, word_count);

endinterface

//--- hw/press_debounce.sv
`timescale 1ns/10ps
`include "loader_cfg.svh"

module press_debounce #(
    parameter int CYCLES = `DEBOUNCE_CYCLES
) (
    input  logic clk,
    input  logic rst,
    input  logic btn,
    output logic press
);
    localparam int CW = $clog2(CYCLES + 1);

    logic [CW-1:0] stable_cnt; // Cycles since btn last changed
    logic          sampled;    // Last seen raw level
    logic          level;      // Debounced level
    logic          level_q;    // Delayed copy for edge detect

    always_ff @(posedge clk) begin
        if (rst) begin
            stable_cnt <= '0;
            sampled    <= 1'b0;
            level      <= 1'b0;
            level_q    <= 1'b0;
        end else begin
            level_q <= level;
            if (btn != sampled) begin
                sampled    <= btn;      // Bounce, restart the timer
                stable_cnt <= '0;
            end else if (stable_cnt < CW'(CYCLES)) begin
                stable_cnt <= stable_cnt + 1'b1;
            end else begin
                level <= sampled;       // Stable long enough
            end
        end
    end

    // Single pulse on debounced rising edge
    assign press = level & ~level_q;

endmodule

//--- hw/sector_counter.sv
`timescale 1ns/10ps
`include "loader_cfg.svh"

module sector_counter #(
    parameter int GROUP_SECTORS = `SECTORS_PER_GROUP
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                sector_start, // Clear byte count, latch sector number
    input  logic                byte_step,
    input  logic                next_group,
    output logic                last_byte,
    output logic                group_full,
    output loader_pkg::sector_t sector
);
    import loader_pkg::*;

    localparam int BW = $clog2(`SECTOR_BYTES);
    localparam int SW = $clog2(GROUP_SECTORS + 1);
    localparam int GW = $clog2(`GROUP_COUNT);

    logic [BW-1:0] byte_cnt;   // Bytes seen in current sector
    logic [SW-1:0] sector_idx; // Sectors finished in this group
    logic [GW-1:0] group_idx;  // Which of the groups is active
    sector_t       base;       // First sector of the group

    assign last_byte  = byte_step && (byte_cnt == BW'(`SECTOR_BYTES - 1));
    assign group_full = (sector_idx == SW'(GROUP_SECTORS));

    always_ff @(posedge clk) begin
        if (rst) begin
            byte_cnt   <= '0;
            sector_idx <= '0;
            group_idx  <= '0;
            base       <= '0;
            sector     <= '0;
        end else begin
            if (sector_start) begin
                byte_cnt <= '0;
                sector   <= base + sector_t'(sector_idx);
            end else if (byte_step) begin
                byte_cnt <= byte_cnt + 1'b1;
            end

            if (next_group) begin
                sector_idx <= '0;
                if (group_idx == GW'(`GROUP_COUNT - 1)) begin
                    group_idx <= '0; // Wrap back to sector 0
                    base      <= '0;
                end else begin
                    group_idx <= group_idx + 1'b1;
                    base      <= base + sector_t'(`GROUP_STRIDE);
                end
            end else if (last_byte) begin
                sector_idx <= sector_idx + 1'b1;
            end
        end
    end

endmodule

//--- hw/load_fsm.sv
`timescale 1ns/10ps

module load_fsm (
    input  logic              clk,
    input  logic              rst,
    input  logic              sd_ready,
    input  logic              sd_byte_valid,
    input  loader_pkg::byte_t sd_byte,
    output logic              sd_rd,
    input  logic              press,
    input  logic              last_byte,
    input  logic              group_full,
    output logic              sector_start,
    output logic              byte_step,
    output logic              next_group,
    output logic              sum_start,
    input  logic              sum_finished,
    buf_if.writer             bus,
    output logic              done
);
    import loader_pkg::*;

    load_state_t state;
    load_state_t state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= INIT;
            sd_rd <= 1'b0;
        end else begin
            state <= state_next;
            sd_rd <= (state == WAIT_READY) && sd_ready; // High in first READ cycle only
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            INIT:        state_next = WAIT_READY;
            WAIT_READY:  if (sd_ready) state_next = READ;
            READ:        if (last_byte) state_next = WAIT_SECTOR;
            WAIT_SECTOR: begin
                if (sd_ready) begin
                    state_next = group_full ? SUM : INIT;
                end
            end
            SUM:         if (sum_finished) state_next = DONE;
            DONE:        if (press) state_next = INIT; // Presses elsewhere are dropped
            default:     state_next = INIT;
        endcase
    end

    assign sector_start = (state == INIT);
    assign byte_step    = (state == READ) && sd_byte_valid; // Bytes taken only in READ
    assign next_group   = (state == DONE) && press;
    assign sum_start    = (state == WAIT_SECTOR) && sd_ready && group_full;

    // Accepted byte goes straight on to the buffer
    assign bus.byte_valid = byte_step;
    assign bus.byte_data  = sd_byte;
    assign bus.clear      = next_group; // New group starts empty

    assign done = (state == DONE);

endmodule

//--- hw/sector_buffer.sv
`timescale 1ns/10ps
`include "loader_cfg.svh"

module sector_buffer #(
    parameter int GROUP_SECTORS = `SECTORS_PER_GROUP
) (
    input logic   clk,
    input logic   rst,
    buf_if.store  bus
);
    import loader_pkg::*;

    localparam int DEPTH = GROUP_SECTORS * `SECTOR_BYTES / 2;
    localparam int AW    = $clog2(DEPTH);

    word_t       mem [DEPTH];
    byte_t       high_byte; // First byte of the pair
    logic        have_high; // Pair half filled
    logic [AW:0] wr_addr;   // One wider so a full buffer shows its count

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_addr   <= '0;
            have_high <= 1'b0;
        end else if (bus.clear) begin
            wr_addr   <= '0;
            have_high <= 1'b0;
        end else if (bus.byte_valid) begin
            have_high <= ~have_high;
            if (have_high) begin
                wr_addr <= wr_addr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.byte_valid && !have_high) begin
            high_byte <= bus.byte_data;
        end
        if (bus.byte_valid && have_high) begin
            mem[wr_addr[AW-1:0]] <= {high_byte, bus.byte_data}; // First byte high
        end
        bus.rd_data <= mem[bus.rd_addr]; // Registered read
    end

    assign bus.word_count = wr_addr;

endmodule

//--- hw/mod_checksum.sv
`timescale 1ns/10ps
`include "loader_cfg.svh"

module mod_checksum #(
    parameter int AW = $clog2(`SECTORS_PER_GROUP * `SECTOR_BYTES / 2)
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    buf_if.reader             bus,
    output logic              finished,
    output loader_pkg::word_t sum
);
    import loader_pkg::*;

    localparam logic [16:0] MOD = 17'(`CHECKSUM_MOD);

    logic [AW-1:0] addr;
    logic          busy;
    logic          acc_phase; // Low while fetching, high when rd_data is valid
    logic          last_word;
    logic [16:0]   sum_raw;
    logic [16:0]   sum_once;
    logic [16:0]   sum_twice;

    assign bus.rd_addr = addr;
    assign last_word   = ({1'b0, addr} + 1'b1) == bus.word_count;

    // Sum can exceed twice the modulus by a few, so subtract up to two times
    always_comb begin
        sum_raw   = {1'b0, sum} + {1'b0, bus.rd_data};
        sum_once  = (sum_raw >= MOD) ? sum_raw - MOD : sum_raw;
        sum_twice = (sum_once >= MOD) ? sum_once - MOD : sum_once;
    end

    assign finished = busy && acc_phase && last_word; // Same edge as final sum

    always_ff @(posedge clk) begin
        if (rst) begin
            addr      <= '0;
            busy      <= 1'b0;
            acc_phase <= 1'b0;
            sum       <= '0;
        end else if (start) begin
            addr      <= '0;
            busy      <= 1'b1;
            acc_phase <= 1'b0;
            sum       <= '0;
        end else if (busy) begin
            acc_phase <= ~acc_phase;
            if (acc_phase) begin
                sum <= sum_twice[15:0];
                if (last_word) begin
                    busy <= 1'b0;
                end else begin
                    addr <= addr + 1'b1;
                end
            end
        end
    end

endmodule

//--- hw/sector_loader_top.sv
`timescale 1ns/10ps
`include "loader_cfg.svh"

module sector_loader_top #(
    parameter int DEBOUNCE_LEN  = `DEBOUNCE_CYCLES,
    parameter int GROUP_SECTORS = `SECTORS_PER_GROUP
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        btn,
    input  logic        sd_ready,
    input  logic        sd_byte_valid,
    input  logic [7:0]  sd_byte,
    output logic        sd_rd,
    output logic [31:0] sd_sector,
    output logic [15:0] checksum,
    output logic        done
);
    localparam int AW = $clog2(GROUP_SECTORS * `SECTOR_BYTES / 2);

    logic press;
    logic last_byte;
    logic group_full;
    logic sector_start;
    logic byte_step;
    logic next_group;
    logic sum_start;
    logic sum_finished;

    buf_if #(.AW(AW)) bus ();

    press_debounce #(.CYCLES(DEBOUNCE_LEN)) u_debounce (
        .clk   (clk),
        .rst   (rst),
        .btn   (btn),
        .press (press)
    );

    sector_counter #(.GROUP_SECTORS(GROUP_SECTORS)) u_counter (
        .clk          (clk),
        .rst          (rst),
        .sector_start (sector_start),
        .byte_step    (byte_step),
        .next_group   (next_group),
        .last_byte    (last_byte),
        .group_full   (group_full),
        .sector       (sd_sector)    // Held from INIT to next INIT
    );

    load_fsm u_fsm (
        .clk           (clk),
        .rst           (rst),
        .sd_ready      (sd_ready),
        .sd_byte_valid (sd_byte_valid),
        .sd_byte       (sd_byte),
        .sd_rd         (sd_rd),
        .press         (press),
        .last_byte     (last_byte),
        .group_full    (group_full),
        .sector_start  (sector_start),
        .byte_step     (byte_step),
        .next_group    (next_group),
        .sum_start     (sum_start),
        .sum_finished  (sum_finished),
        .bus           (bus.writer),
        .done          (done)
    );

    sector_buffer #(.GROUP_SECTORS(GROUP_SECTORS)) u_buffer (
        .clk (clk),
        .rst (rst),
        .bus (bus.store)
    );

    mod_checksum #(.AW(AW)) u_checksum (
        .clk      (clk),
        .rst      (rst),
        .start    (sum_start),
        .bus      (bus.reader),
        .finished (sum_finished),
        .sum      (checksum)     // Register output, valid when done rises
    );

endmodule

//--- verif/tb_sector_loader.sv
`timescale 1ns/10ps
`include "loader_cfg.svh"

module tb_sector_loader #(
    parameter int DEBOUNCE = 8,
    parameter int SECTORS  = `SECTORS_PER_GROUP
);
    // Each group needs byte cycles with gaps, the sum pass and one press
    localparam int GROUP_CYCLES = SECTORS * (3 * `SECTOR_BYTES + 32) + 4 * DEBOUNCE + 100;
    localparam int CYCLE_LIMIT  = 16 * GROUP_CYCLES; // About 100000 with defaults
    localparam int REQ_WAIT     = 64;
    localparam int SUM_WAIT     = SECTORS * `SECTOR_BYTES + 64; // Two cycles per word

    logic        clk;
    logic        rst;
    logic        btn;
    logic        sd_ready;
    logic        sd_byte_valid;
    logic [7:0]  sd_byte;
    logic        sd_rd;
    logic [31:0] sd_sector;
    logic [15:0] checksum;
    logic        done;

    logic [31:0] lcg_state;
    logic [7:0]  sent_bytes[$]; // Bytes of the group now loading
    int          cycles;
    int          group_idx;     // Groups loaded so far

    sector_loader_top #(.DEBOUNCE_LEN(DEBOUNCE), .GROUP_SECTORS(SECTORS)) dut0 (
        .clk           (clk),
        .rst           (rst),
        .btn           (btn),
        .sd_ready      (sd_ready),
        .sd_byte_valid (sd_byte_valid),
        .sd_byte       (sd_byte),
        .sd_rd         (sd_rd),
        .sd_sector     (sd_sector),
        .checksum      (checksum),
        .done          (done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk; // 40 ns period
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        assert (cycles <= CYCLE_LIMIT) else abort_run(
            $sformatf("Timeout, the run went past %0d cycles", CYCLE_LIMIT));
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    // Inputs change and outputs are sampled 2 ns after the edge
    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    function automatic logic [7:0] lcg_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16]; // Middle bits since low bits cycle too fast
    endfunction

    // Pairs put the first byte high and each word is added then reduced
    function automatic logic [15:0] ref_checksum();
        int unsigned acc;
        int unsigned pair_word;
        int          i;
        acc = 0;
        for (i = 0; i + 1 < sent_bytes.size(); i += 2) begin
            pair_word = {sent_bytes[i], sent_bytes[i + 1]};
            acc       = (acc + pair_word) % `CHECKSUM_MOD;
        end
        return acc[15:0];
    endfunction

    function automatic int unsigned group_base(input int idx);
        return (idx % `GROUP_COUNT) * `GROUP_STRIDE; // Wraps to 0 after the last group
    endfunction

    task automatic wait_for_request(input int unsigned expected);
        int n;
        n = 0;
        while (!sd_rd) begin
            tick();
            n++;
            assert (n <= REQ_WAIT) else abort_run("No read request came from the loader");
        end
        assert (sd_sector == 32'(expected)) else abort_run($sformatf(
            "ERROR: sd_sector = 0x%08h, expected 0x%08h", sd_sector, 32'(expected)));
    endtask

    // SD source holds ready low while streaming and may stall afterwards
    task automatic stream_sector(input int stall);
        logic [7:0] b;
        int         i;
        sd_ready = 1'b0;
        for (i = 0; i < `SECTOR_BYTES; i++) begin
            b             = lcg_byte();
            sd_byte       = b;
            sd_byte_valid = 1'b1;
            sent_bytes.push_back(b);
            tick();
            assert (sd_rd == 1'b0 && done == 1'b0) else abort_run($sformatf(
                "ERROR: sd_rd = 0x%h, done = 0x%h, expected 0x0 while streaming", sd_rd, done));
            sd_byte_valid = 1'b0; // One idle cycle between bytes
            tick();
            assert (sd_rd == 1'b0 && done == 1'b0) else abort_run($sformatf(
                "ERROR: sd_rd = 0x%h, done = 0x%h, expected 0x0 while streaming", sd_rd, done));
        end
        repeat (stall) begin
            tick();
            assert (sd_rd == 1'b0) else abort_run($sformatf(
                "ERROR: sd_rd = 0x%h, expected 0x0 while sd_ready is low", sd_rd));
        end
        sd_ready = 1'b1;
    endtask

    task automatic load_group(input int unsigned base, input int stall_sector);
        int s;
        int n;
        sent_bytes.delete();
        for (s = 0; s < SECTORS; s++) begin
            wait_for_request(base + s);
            stream_sector((s == stall_sector) ? 20 : 0);
        end
        n = 0;
        while (!done) begin
            tick();
            n++;
            assert (n <= SUM_WAIT) else abort_run("Done never rose after the last sector");
        end
        assert (checksum == ref_checksum()) else abort_run($sformatf(
            "ERROR: checksum = 0x%04h, expected 0x%04h", checksum, ref_checksum()));
        group_idx++;
    endtask

    // Button stays high until done drops and is released as the next load starts
    task automatic press_button();
        int n;
        btn = 1'b1;
        n   = 0;
        while (done) begin
            tick();
            n++;
            assert (n <= DEBOUNCE + 8) else abort_run(
                "Button press did not leave the done state");
        end
        btn = 1'b0;
    endtask

    task automatic stray_press();
        repeat (200) tick(); // Well inside the first sector
        btn = 1'b1;
        repeat (DEBOUNCE + 10) tick();
        btn = 1'b0;
        repeat (DEBOUNCE + 10) tick();
    endtask

    task automatic after_reset();
        assert (sd_rd == 1'b0 && done == 1'b0 && checksum == 16'h0) else abort_run(
            $sformatf("ERROR: sd_rd = 0x%h, done = 0x%h, checksum = 0x%04h, expected 0",
                      sd_rd, done, checksum));
        repeat (4) begin
            tick();
            assert (sd_rd == 1'b0) else abort_run($sformatf(
                "ERROR: sd_rd = 0x%h, expected 0x0 with sd_ready low", sd_rd));
        end
    endtask

    task automatic first_group_load();
        sd_ready = 1'b1;
        load_group(group_base(group_idx), -1);
    endtask

    task automatic short_press_ignored();
        btn = 1'b1;
        repeat ((DEBOUNCE > 2) ? DEBOUNCE / 2 : 1) tick();
        btn = 1'b0;
        repeat (2 * DEBOUNCE + 10) begin
            tick();
            assert (done == 1'b1 && sd_rd == 1'b0) else abort_run($sformatf(
                "ERROR: done = 0x%h, sd_rd = 0x%h after a short press, expected 0x1 and 0x0",
                done, sd_rd));
        end
    endtask

    task automatic ready_stall_resume();
        press_button();
        load_group(group_base(group_idx), 0); // 20 stalled cycles after sector 0
    endtask

    task automatic group_walk();
        int g;
        for (g = 0; g < 4; g++) begin
            press_button();
            if (g == 1) begin
                fork
                    load_group(group_base(group_idx), -1);
                    stray_press();
                join
            end else begin
                load_group(group_base(group_idx), -1);
            end
        end
    endtask

    initial begin
        rst           = 1'b1;
        btn           = 1'b0;
        sd_ready      = 1'b0;
        sd_byte_valid = 1'b0;
        sd_byte       = 8'h00;
        lcg_state     = 32'd31;
        cycles        = 0;
        group_idx     = 0;
        repeat (3) tick();
        rst = 1'b0;
        after_reset();
        first_group_load();
        short_press_ignored();
        ready_stall_resume();
        group_walk();   // Bases 200, 300, 400, then back to 0
        $display(">>> PASS");
        $finish;
    end

endmodule

//--- flist.f
+incdir+include
hw/loader_pkg.sv
hw/buf_if.sv
hw/press_debounce.sv
hw/sector_counter.sv
hw/load_fsm.sv
hw/sector_buffer.sv
hw/mod_checksum.sv
hw/sector_loader_top.sv
verif/tb_sector_loader.sv

//--- Makefile
# Verilator build and run for the sector loader testbench

VERILATOR ?= verilator
TOP       ?= tb_sector_loader
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
DEBOUNCE  ?= 8
SECTORS   ?= 4
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT := >>> PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR DEBOUNCE SECTORS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GDEBOUNCE=$(DEBOUNCE) -GSECTORS=$(SECTORS) \
		-Mdir $(BUILD_DIR) -o V$(TOP) -f $(FLIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)
